// File: common/sm_defines.svh
`ifndef SM_DEFINES_SVH
`define SM_DEFINES_SVH

// cpu word width
`define SM_WORD_W 16

// byte step between memory words
`define SM_ADDR_STEP 2

// one-hot register file destinations
`define SM_DEST_R0  16'h0001
`define SM_DEST_R15 16'h8000

`endif

// File: common/sm_cmd_pkg.sv
`default_nettype none
`include "sm_defines.svh"

package sm_cmd_pkg;

    typedef logic [`SM_WORD_W-1:0] sm_word_t;

    // one flag per command, held stable while busy
    typedef struct packed {
        logic id;
        logic id_prev;
        logic sm_disable;
    } sm_cmd_t;

    // field requests to the SM table
    typedef enum logic [2:0] {
        req_none      = 3'd0,
        req_pub_start = 3'd1,
        req_pub_end   = 3'd2,
        req_sec_start = 3'd3,
        req_sec_end   = 3'd4,
        req_id        = 3'd5
    } sm_req_e;

    typedef struct packed {
        sm_word_t pc;
        sm_word_t r15;
        sm_word_t prev_id;
    } cpu_regs_t;

    // dest is one hot over r0..r15
    typedef struct packed {
        logic     write;
        sm_word_t dest;
        sm_word_t data;
    } reg_wb_t;

    typedef struct packed {
        logic wr;
        logic z;
    } stat_t;

endpackage

`default_nettype wire

// File: common/sm_mem_pkg.sv
`default_nettype none
`include "sm_defines.svh"

package sm_mem_pkg;

    typedef struct packed {
        logic                  en;
        logic [1:0]            wr;
        logic [`SM_WORD_W-1:0] addr;
        logic [`SM_WORD_W-1:0] data;
    } mem_bus_t;

    // base and limit loads, or a step to the next word
    typedef struct packed {
        logic                  base_load;
        logic [`SM_WORD_W-1:0] base;
        logic                  limit_load;
        logic [`SM_WORD_W-1:0] limit;
        logic                  step;
    } range_ctl_t;

endpackage

`default_nettype wire

// File: source/addr_range_walker.sv
`timescale 1ns/10ps
`default_nettype none
`include "sm_defines.svh"

module addr_range_walker (
    input  wire                         clk,
    input  wire                         reset,
    input  wire sm_mem_pkg::range_ctl_t range,
    output sm_cmd_pkg::sm_word_t        addr,
    output logic                        range_done
);
    import sm_cmd_pkg::*;

    sm_word_t limit_q;

    always_ff @(posedge clk)
    begin
        if (reset)
            addr <= '0;
        else if (range.base_load)
            addr <= range.base;
        else if (range.step)
            addr <= addr + sm_word_t'(`SM_ADDR_STEP);
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            limit_q <= '0;
        else if (range.limit_load)
            limit_q <= range.limit;
    end

    // limit is exclusive
    assign range_done = (addr >= limit_q);

    assert property (@(posedge clk) disable iff (reset) !(range.base_load && range.step));

endmodule

`default_nettype wire

// File: source/sm_select.sv
`timescale 1ns/10ps
`default_nettype none

module sm_select (
    input  wire                        clk,
    input  wire                        reset,
    input  wire sm_cmd_pkg::sm_cmd_t   cmd,
    input  wire sm_cmd_pkg::cpu_regs_t regs,
    input  wire                        sm_data_valid,
    input  wire                        sm_pc_valid,
    output sm_cmd_pkg::sm_word_t       sm_addr,
    output logic                       sm_valid
);
    logic valid_d;

    // id looks up the SM around r15, the rest use the pc
    assign sm_addr = cmd.id ? regs.r15 : regs.pc;

    always_comb
    begin
        if (cmd.id)
            valid_d = sm_data_valid;
        else if (cmd.sm_disable)
            valid_d = sm_pc_valid;
        else
            valid_d = cmd.id_prev;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
            sm_valid <= 1'b0;
        else
            sm_valid <= valid_d;
    end

    assert property (@(posedge clk) reset |=> !sm_valid);

endmodule

`default_nettype wire

// File: sequencer/cmd_sequencer.sv
`timescale 1ns/10ps
`default_nettype none
`include "sm_defines.svh"

module cmd_sequencer (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire sm_cmd_pkg::sm_cmd_t   cmd,
    input  wire sm_cmd_pkg::cpu_regs_t regs,
    input  wire                        irq_pnd,
    input  wire sm_cmd_pkg::sm_word_t  sm_data,
    input  wire                        sm_valid,
    input  wire                        range_done,
    output logic                       busy,
    output sm_cmd_pkg::sm_req_e        sm_request,
    output sm_mem_pkg::range_ctl_t     range,
    output logic                       mem_en,
    output logic [1:0]                 mem_wr,
    output sm_cmd_pkg::reg_wb_t        wb,
    output sm_cmd_pkg::stat_t          stat
);
    import sm_cmd_pkg::*;
    import sm_mem_pkg::*;

    typedef enum logic [3:0] {
        st_idle,
        st_check,
        st_code_base,
        st_code_limit,
        st_clear_code,
        st_data_base,
        st_data_limit,
        st_clear_data,
        st_fail,
        st_irq_fail,
        st_success,
        st_wait
    } state_e;

    state_e  state;
    state_e  next_state;
    logic    irq_abort;
    reg_wb_t wb_d;
    stat_t   stat_d;

    // check and the result states always run to completion
    assign irq_abort = irq_pnd &&
        !(state inside {st_idle, st_check, st_success, st_fail, st_irq_fail});

    always_comb
    begin
        next_state = state;
        if (irq_abort)
        begin
            next_state = st_irq_fail;
        end
        else
        begin
            case (state)
                st_idle:
                    next_state = start ? st_check : st_idle;
                st_check:
                begin
                    if (!sm_valid)
                        next_state = st_fail;
                    else if (cmd.id || cmd.id_prev)
                        next_state = st_success;
                    else if (cmd.sm_disable)
                        next_state = st_code_base;
                    else
                        next_state = st_fail;
                end
                st_code_base:  next_state = st_code_limit;
                st_code_limit: next_state = st_clear_code;
                st_clear_code: next_state = range_done ? st_data_base : st_clear_code;
                st_data_base:  next_state = st_data_limit;
                st_data_limit: next_state = st_clear_data;
                st_clear_data: next_state = range_done ? st_success : st_clear_data;
                st_success:    next_state = cmd.sm_disable ? st_wait : st_idle;
                default:       next_state = st_idle;
            endcase
        end
    end

    assign busy = (state != st_idle);

    // decode for the state being entered
    always_comb
    begin
        sm_request = req_none;
        range      = '0;
        mem_en     = 1'b0;
        mem_wr     = 2'b00;
        wb_d       = '0;
        stat_d     = '0;
        case (next_state)
            st_code_base:
            begin
                sm_request      = req_pub_start;
                range.base_load = 1'b1;
                range.base      = sm_data;
            end
            st_code_limit:
            begin
                sm_request       = req_pub_end;
                range.limit_load = 1'b1;
                range.limit      = sm_data;
            end
            st_data_base:
            begin
                sm_request      = req_sec_start;
                range.base_load = 1'b1;
                range.base      = sm_data;
            end
            st_data_limit:
            begin
                sm_request       = req_sec_end;
                range.limit_load = 1'b1;
                range.limit      = sm_data;
            end
            st_clear_code, st_clear_data:
            begin
                mem_en     = 1'b1;
                mem_wr     = 2'b11;
                range.step = 1'b1;
            end
            st_success:
            begin
                wb_d.write = 1'b1;
                stat_d.wr  = 1'b1;
                if (cmd.sm_disable)
                begin
                    // jump to the address the caller left in r15
                    wb_d.dest = `SM_DEST_R0;
                    wb_d.data = regs.r15;
                end
                else if (cmd.id)
                begin
                    sm_request = req_id;
                    wb_d.dest  = `SM_DEST_R15;
                    wb_d.data  = sm_data;
                end
                else
                begin
                    wb_d.dest = `SM_DEST_R15;
                    wb_d.data = regs.prev_id;
                end
            end
            st_fail, st_irq_fail:
            begin
                wb_d.write = 1'b1;
                wb_d.dest  = `SM_DEST_R15;
                stat_d.wr  = 1'b1;
                // zero flag tells an abort apart from a bad SM
                stat_d.z   = (next_state == st_irq_fail);
            end
            default:
            begin
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        wb   <= wb_d;
        stat <= stat_d;
        if (reset)
        begin
            state    <= st_idle;
            wb.write <= 1'b0;
            stat.wr  <= 1'b0;
        end
        else
        begin
            state <= next_state;
        end
    end

    assert property (@(posedge clk) disable iff (reset) (mem_wr != 2'b00) |-> mem_en);

    // results never come on two cycles in a row
    assert property (@(posedge clk) disable iff (reset) wb.write |=> !wb.write);

endmodule

`default_nettype wire

// File: source/sm_command_unit.sv
`timescale 1ns/10ps
`default_nettype none

module sm_command_unit (
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        start,
    input  wire sm_cmd_pkg::sm_cmd_t   cmd,
    input  wire sm_cmd_pkg::cpu_regs_t regs,
    input  wire                        irq_pnd,
    input  wire sm_cmd_pkg::sm_word_t  sm_data,
    input  wire                        sm_data_valid,
    input  wire                        sm_pc_valid,
    output logic                       busy,
    output sm_cmd_pkg::sm_req_e        sm_request,
    output sm_cmd_pkg::sm_word_t       sm_addr,
    output sm_mem_pkg::mem_bus_t       mem,
    output sm_cmd_pkg::reg_wb_t        wb,
    output sm_cmd_pkg::stat_t          stat
);
    import sm_cmd_pkg::*;
    import sm_mem_pkg::*;

    range_ctl_t range;
    sm_word_t   walk_addr;
    logic       range_done;
    logic       sm_valid;
    logic       mem_en;
    logic [1:0] mem_wr;

    cmd_sequencer u_seq (
        .clk        (clk),
        .reset      (reset),
        .start      (start),
        .cmd        (cmd),
        .regs       (regs),
        .irq_pnd    (irq_pnd),
        .sm_data    (sm_data),
        .sm_valid   (sm_valid),
        .range_done (range_done),
        .busy       (busy),
        .sm_request (sm_request),
        .range      (range),
        .mem_en     (mem_en),
        .mem_wr     (mem_wr),
        .wb         (wb),
        .stat       (stat)
    );

    addr_range_walker u_walk (
        .clk        (clk),
        .reset      (reset),
        .range      (range),
        .addr       (walk_addr),
        .range_done (range_done)
    );

    sm_select u_sel (
        .clk           (clk),
        .reset         (reset),
        .cmd           (cmd),
        .regs          (regs),
        .sm_data_valid (sm_data_valid),
        .sm_pc_valid   (sm_pc_valid),
        .sm_addr       (sm_addr),
        .sm_valid      (sm_valid)
    );

    // the unit only ever writes zeros
    assign mem = '{en: mem_en, wr: mem_wr, addr: walk_addr, data: '0};

endmodule

`default_nettype wire

// File: tests/tb_sm_command_unit.sv
`timescale 1ns/10ps
`default_nettype none
`include "sm_defines.svh"

module tb_sm_command_unit;
    import sm_cmd_pkg::*;
    import sm_mem_pkg::*;

    // one vector line, SM table included
    typedef struct packed {
        sm_cmd_t   cmd;
        cpu_regs_t regs;
        sm_word_t  pub_start;
        sm_word_t  pub_end;
        sm_word_t  sec_start;
        sm_word_t  sec_end;
        sm_word_t  sm_id;
        sm_word_t  irq_at;
        reg_wb_t   exp_wb;
        stat_t     exp_stat;
    } vec_t;

    logic      clk;
    logic      reset;
    logic      start;
    sm_cmd_t   cmd;
    cpu_regs_t regs;
    logic      irq_pnd;
    sm_word_t  sm_data;
    logic      sm_data_valid;
    logic      sm_pc_valid;
    logic      busy;
    sm_req_e   sm_request;
    sm_word_t  sm_addr;
    mem_bus_t  mem;
    reg_wb_t   wb;
    stat_t     stat;

    vec_t      cur;
    vec_t      vecs[$];
    mem_bus_t  got_writes[$];
    int        err_count;
    int        cycle_count;
    int        cycle_limit;

    sm_command_unit u_dut (
        .clk           (clk),
        .reset         (reset),
        .start         (start),
        .cmd           (cmd),
        .regs          (regs),
        .irq_pnd       (irq_pnd),
        .sm_data       (sm_data),
        .sm_data_valid (sm_data_valid),
        .sm_pc_valid   (sm_pc_valid),
        .busy          (busy),
        .sm_request    (sm_request),
        .sm_addr       (sm_addr),
        .mem           (mem),
        .wb            (wb),
        .stat          (stat)
    );

    always #4 clk = ~clk;

    function automatic logic in_sm(input sm_word_t a, input vec_t t);
        return (a >= t.pub_start && a < t.pub_end) ||
               (a >= t.sec_start && a < t.sec_end);
    endfunction

    function automatic int range_words(input vec_t t);
        return (int'(t.pub_end) - int'(t.pub_start) + 1) / 2 +
               (int'(t.sec_end) - int'(t.sec_start) + 1) / 2;
    endfunction

    // SM table answers in the same cycle
    always_comb
    begin
        case (sm_request)
            req_pub_start: sm_data = cur.pub_start;
            req_pub_end:   sm_data = cur.pub_end;
            req_sec_start: sm_data = cur.sec_start;
            req_sec_end:   sm_data = cur.sec_end;
            req_id:        sm_data = cur.sm_id;
            default:       sm_data = '0;
        endcase
    end

    assign sm_data_valid = in_sm(sm_addr, cur);
    assign sm_pc_valid   = in_sm(regs.pc, cur);

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_limit != 0 && cycle_count >= cycle_limit)
        begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display(">>> FAIL");
            $finish;
        end
    end

    task automatic check_wb(input reg_wb_t got, input reg_wb_t exp, input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED @%0t: %s wb write/dest/data %b/%h/%h, expected %b/%h/%h",
                     $time, what, got.write, got.dest, got.data, exp.write, exp.dest, exp.data);
        end
    endtask

    task automatic check_stat(input stat_t got, input stat_t exp, input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED @%0t: %s stat wr/z %b/%b, expected %b/%b",
                     $time, what, got.wr, got.z, exp.wr, exp.z);
        end
    endtask

    task automatic check_mem(input mem_bus_t got, input mem_bus_t exp, input string what);
        if (got !== exp)
        begin
            err_count++;
            $display("CHECK FAILED @%0t: %s mem en/wr/addr/data %b/%b/%h/%h, expected %b/%b/%h/%h",
                     $time, what, got.en, got.wr, got.addr, got.data,
                     exp.en, exp.wr, exp.addr, exp.data);
        end
    endtask

    task automatic check_idle(input int n, input vec_t v);
        sm_word_t exp_addr;

        if (busy || mem.en || mem.wr != 2'b00 || wb.write || stat.wr ||
            sm_request != req_none)
        begin
            err_count++;
            $display("test %0d: the unit is not idle before start", n);
        end
        // lookup address is r15 for id and the pc for disable
        if (v.cmd.id || v.cmd.sm_disable)
        begin
            exp_addr = v.cmd.id ? v.regs.r15 : v.regs.pc;
            if (sm_addr !== exp_addr)
            begin
                err_count++;
                $display("CHECK FAILED @%0t: test %0d sm_addr %h, expected %h",
                         $time, n, sm_addr, exp_addr);
            end
        end
    endtask

    task automatic read_vectors();
        int       fd;
        int       rc;
        string    line;
        sm_word_t f [13];
        vec_t     v;

        fd = $fopen("tests/sm_command_vectors.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open tests/sm_command_vectors.txt");
            $display(">>> FAIL");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                rc = $fgets(line, fd);
                if (rc > 0 && line.len() > 1 && line[0] != "#")
                begin
                    rc = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                 f[0], f[1], f[2], f[3], f[4], f[5], f[6],
                                 f[7], f[8], f[9], f[10], f[11], f[12]);
                    if (rc == 13)
                    begin
                        v.cmd       = f[0][2:0];
                        v.regs      = '{pc: f[1], r15: f[2], prev_id: f[3]};
                        v.pub_start = f[4];
                        v.pub_end   = f[5];
                        v.sec_start = f[6];
                        v.sec_end   = f[7];
                        v.sm_id     = f[8];
                        v.irq_at    = f[9];
                        v.exp_wb    = '{write: 1'b1, dest: f[10], data: f[11]};
                        v.exp_stat  = '{wr: 1'b1, z: f[12][0]};
                        vecs.push_back(v);
                    end
                    else
                    begin
                        err_count++;
                        $display("vector line could not be parsed: %s", line);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int n);
        vec_t     v;
        mem_bus_t exp_writes[$];
        reg_wb_t  got_wb;
        stat_t    got_stat;
        sm_word_t a;
        int       cyc;
        int       res_cyc;
        int       end_wait;
        int       errs_before;
        int       gap;

        v = vecs[n];
        errs_before = err_count;
        got_writes.delete();
        @(posedge clk);
        cur     <= v;
        cmd     <= v.cmd;
        regs    <= v.regs;
        irq_pnd <= 1'b0;
        gap = $urandom_range(8, 1);
        repeat (gap)
        begin
            @(negedge clk);
            check_idle(n, v);
            @(posedge clk);
        end
        start <= 1'b1;
        cyc = 0;
        res_cyc = -1;
        forever
        begin
            @(negedge clk);
            if (mem.en || mem.wr != 2'b00)
            begin
                if (res_cyc >= 0 || irq_pnd)
                begin
                    err_count++;
                    $display("test %0d: memory write to %h after the result or the interrupt",
                             n, mem.addr);
                end
                got_writes.push_back(mem);
            end
            if (wb.write && res_cyc >= 0)
            begin
                err_count++;
                $display("test %0d: a second register write appeared", n);
            end
            else if (wb.write)
            begin
                res_cyc  = cyc;
                got_wb   = wb;
                got_stat = stat;
            end
            if (res_cyc >= 0 && !busy)
                break;
            @(posedge clk);
            cyc++;
            start <= 1'b0;
            if (v.irq_at != 0 && cyc == v.irq_at)
                irq_pnd <= 1'b1;
        end
        @(posedge clk);
        irq_pnd <= 1'b0;

        check_wb(got_wb, v.exp_wb, $sformatf("test %0d", n));
        check_stat(got_stat, v.exp_stat, $sformatf("test %0d", n));
        if (!v.cmd.sm_disable && res_cyc != 2)
        begin
            err_count++;
            $display("CHECK FAILED @%0t: test %0d result %0d cycles after start, expected 2",
                     $time, n, res_cyc);
        end
        // busy stays up one cycle more after a good disable
        end_wait = (v.exp_wb.dest == `SM_DEST_R0) ? 2 : 1;
        if (cyc != res_cyc + end_wait)
        begin
            err_count++;
            $display("CHECK FAILED @%0t: test %0d busy fell %0d cycles after the result",
                     $time, n, cyc - res_cyc);
        end

        if (v.cmd.sm_disable && in_sm(v.regs.pc, v))
        begin
            a = v.pub_start;
            do
            begin
                exp_writes.push_back('{en: 1'b1, wr: 2'b11, addr: a, data: '0});
                a += `SM_ADDR_STEP;
            end while (a < v.pub_end);
            a = v.sec_start;
            do
            begin
                exp_writes.push_back('{en: 1'b1, wr: 2'b11, addr: a, data: '0});
                a += `SM_ADDR_STEP;
            end while (a < v.sec_end);
        end
        // an abort leaves only a leading part of the clear
        if (got_writes.size() > exp_writes.size() ||
            (v.irq_at == 0 && got_writes.size() != exp_writes.size()))
        begin
            err_count++;
            $display("CHECK FAILED @%0t: test %0d saw %0d memory writes, expected %0d",
                     $time, n, got_writes.size(), exp_writes.size());
        end
        foreach (got_writes[k])
        begin
            if (k < exp_writes.size())
                check_mem(got_writes[k], exp_writes[k], $sformatf("test %0d write %0d", n, k));
        end

        if (err_count == errs_before)
            $display("test %0d cmd %b ok", n, v.cmd);
        else
            $display("test %0d cmd %b failed with %0d errors", n, v.cmd, err_count - errs_before);
    endtask

    initial
    begin
        int words;

        clk         = 1'b0;
        reset       = 1'b1;
        start       = 1'b0;
        cmd         = '0;
        regs        = '0;
        irq_pnd     = 1'b0;
        cur         = '0;
        err_count   = 0;
        cycle_count = 0;
        cycle_limit = 0;
        void'($urandom(97160));
        read_vectors();
        if (vecs.size() == 0)
        begin
            err_count++;
            $display("no test vectors were read");
        end
        words = 0;
        foreach (vecs[k])
            words += range_words(vecs[k]);
        cycle_limit = 30 * vecs.size() + words;

        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int n = 0; n < vecs.size(); n++)
            run_test(n);

        $display("tests run %0d, errors %0d", vecs.size(), err_count);
        if (err_count == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/sm_command_vectors.txt
# cmd pc r15 prev_id pub_start pub_end sec_start sec_end sm_id irq_cycle dest data z
# all columns hex; cmd 4 = id, 2 = id_prev, 1 = disable; irq_cycle 0 = no interrupt
4 0100 0210 0000 0200 0240 0400 0420 0003 00 8000 0003 0
4 0100 041e 0000 0200 0240 0400 0420 0007 00 8000 0007 0
4 0100 0240 0000 0200 0240 0400 0420 0003 00 8000 0000 0
4 0000 0200 0000 0200 0202 0400 0402 0011 00 8000 0011 0
2 0100 0210 0002 0200 0240 0400 0420 0003 00 8000 0002 0
2 0900 0000 0005 0200 0240 0400 0420 0009 00 8000 0005 0
1 0204 1234 0000 0200 0210 0400 0406 0003 00 0001 1234 0
1 0500 0abc 0000 0300 0305 0500 0501 0004 00 0001 0abc 0
1 0600 1234 0000 0200 0210 0400 0406 0003 00 8000 0000 0
1 0210 0000 0000 0200 0210 0400 0406 0003 00 8000 0000 0
1 0210 4444 0000 0200 0240 0400 0410 0003 06 8000 0000 1
1 0404 5555 0000 0200 0210 0400 0440 0003 14 8000 0000 1
4 0100 0432 0000 0200 0240 0400 0440 000a 00 8000 000a 0
1 043f 00ff 0000 0200 0220 0400 0440 0003 00 0001 00ff 0
1 0200 0202 0000 0200 0202 0400 0402 0011 00 0001 0202 0
2 0200 0210 7777 0200 0202 0400 0402 0011 00 8000 7777 0

// File: tb.f
+incdir+common
common/sm_cmd_pkg.sv
common/sm_mem_pkg.sv
source/addr_range_walker.sv
source/sm_select.sv
sequencer/cmd_sequencer.sv
source/sm_command_unit.sv
tests/tb_sm_command_unit.sv

// File: Bender.yml
package:
  name: sm_command_unit

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/sm_cmd_pkg.sv
      - common/sm_mem_pkg.sv
      - source/addr_range_walker.sv
      - source/sm_select.sv
      - sequencer/cmd_sequencer.sv
      - source/sm_command_unit.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/tb_sm_command_unit.sv
